// ==== Makefile ====
# Verilator build and run of the sprite display testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_sprite_display
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
MEMFILE   ?= src/letter_f.mem
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: sim clean

# the bitmap is read by name from the working directory of the simulation
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	cp $(MEMFILE) $(OBJ_DIR)/
	cd $(OBJ_DIR) && ./V$(TOP) 2>&1 | tee $(CURDIR)/$(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== src/display_if.sv ====
// ====================
// raster bus: position counters, syncs, strobes
// ====================
`default_nettype none

interface display_if;
    import display_pkg::*;

    logic [CORDW-1:0] sx;     // current column
    logic [CORDW-1:0] sy;     // current line
    logic             hsync;  // horizontal sync level
    logic             vsync;  // vertical sync level
    logic             de;     // active area
    logic             line;   // one cycle at sx == H_RES
    logic             frame;  // one cycle at start of last line

    // timing generator drives everything
    modport source (output sx, sy, hsync, vsync, de, line, frame);

    // sprite engine needs position and strobes
    modport sprite (input sx, sy, line, frame);

    // compose stage only needs the sync/blank levels
    modport compose (input hsync, vsync, de);

endinterface

`default_nettype wire

// ==== src/display_pkg.sv ====
// ====================
// shared localparams for the sprite display
// raster timing, sprite geometry, colours
// ====================
`default_nettype none

package display_pkg;

    localparam int CORDW = 10;          // coordinate width, covers 0..1023

    // horizontal timing in pixels
    localparam int H_RES   = 640;       // active pixels
    localparam int H_FP    = 16;        // front porch
    localparam int H_SYNC  = 96;        // sync pulse
    localparam int H_BP    = 48;        // back porch
    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 800

    // vertical timing in lines
    localparam int V_RES   = 480;       // active lines
    localparam int V_FP    = 10;        // front porch
    localparam int V_SYNC  = 2;         // sync pulse
    localparam int V_BP    = 33;        // back porch
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 525

    // negative syncs, idle high
    localparam logic SYNC_ACTIVE = 1'b0;

    // sprite geometry
    localparam int SPR_WIDTH  = 8;      // bitmap columns
    localparam int SPR_HEIGHT = 8;      // bitmap rows
    localparam int SPR_SCALE  = 4;      // 2^4 = 16x magnification
    localparam int SPR_COLW   = $clog2(SPR_WIDTH);   // column index bits
    localparam int SPR_ROWW   = $clog2(SPR_HEIGHT);  // row index bits
    localparam SPR_FILE = "letter_f.mem";  // one binary row per line

    // colour channels, 4 bits each
    localparam int CHANW = 4;

    // sprite colour: yellow
    localparam logic [CHANW-1:0] FG_R = 4'hF;
    localparam logic [CHANW-1:0] FG_G = 4'hC;
    localparam logic [CHANW-1:0] FG_B = 4'h0;

    // background colour: blue
    localparam logic [CHANW-1:0] BG_R = 4'h1;
    localparam logic [CHANW-1:0] BG_G = 4'h3;
    localparam logic [CHANW-1:0] BG_B = 4'h7;

endpackage

`default_nettype wire

// ==== src/display_timing.sv ====
// ====================
// 640x480 raster timing: counters, syncs,
// data enable, line and frame strobes
// ====================
`default_nettype none

module display_timing (
    input  logic      clk_pix,
    input  logic      reset,
    display_if.source disp
);
    import display_pkg::*;

    logic [CORDW-1:0] sx_nxt;     // position for next cycle
    logic [CORDW-1:0] sy_nxt;
    logic             line_end;   // last pixel of the line
    logic             frame_end;  // last line of the frame
    logic             hs_win;     // next position inside hsync window
    logic             vs_win;     // next position inside vsync window

    // next counter position
    always_comb begin
        line_end  = (disp.sx == CORDW'(H_TOTAL - 1));
        frame_end = (disp.sy == CORDW'(V_TOTAL - 1));
        sx_nxt    = line_end ? '0 : disp.sx + 1'b1;
        sy_nxt    = disp.sy;
        if (line_end) begin
            sy_nxt = frame_end ? '0 : disp.sy + 1'b1;  // wrap at frame end
        end
    end

    // sync windows sit after the front porch
    always_comb begin
        hs_win = (sx_nxt >= CORDW'(H_RES + H_FP))
              && (sx_nxt <  CORDW'(H_RES + H_FP + H_SYNC));
        vs_win = (sy_nxt >= CORDW'(V_RES + V_FP))
              && (sy_nxt <  CORDW'(V_RES + V_FP + V_SYNC));
    end

    // decode from the next position so every output
    // matches the counter value it is registered with
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            disp.sx    <= '0;
            disp.sy    <= '0;
            disp.hsync <= ~SYNC_ACTIVE;  // idle level
            disp.vsync <= ~SYNC_ACTIVE;
            disp.de    <= 1'b0;
            disp.line  <= 1'b0;
            disp.frame <= 1'b0;
        end else begin
            disp.sx    <= sx_nxt;
            disp.sy    <= sy_nxt;
            disp.hsync <= hs_win ? SYNC_ACTIVE : ~SYNC_ACTIVE;
            disp.vsync <= vs_win ? SYNC_ACTIVE : ~SYNC_ACTIVE;
            disp.de    <= (sx_nxt < CORDW'(H_RES)) && (sy_nxt < CORDW'(V_RES));
            disp.line  <= (sx_nxt == CORDW'(H_RES));  // just past active pixels
            // frame strobe on the last line, ahead of line 0
            disp.frame <= (sx_nxt == '0) && (sy_nxt == CORDW'(V_TOTAL - 1));
        end
    end

endmodule

`default_nettype wire

// ==== src/letter_f.mem ====
// one binary row of the letter F per line, leftmost column first
11111110
11111110
11000000
11111100
11111100
11000000
11000000
00000000

// ==== src/pixel_compose.sv ====
// ====================
// colour composition: sync alignment, sprite or
// background colour, blanking, output register
// ====================
`default_nettype none

module pixel_compose (
    input  logic                          clk_pix,
    input  logic                          reset,
    display_if.compose                    disp,
    input  logic                          drawing,
    input  logic                          pix,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          de,
    output logic [display_pkg::CHANW-1:0] r,
    output logic [display_pkg::CHANW-1:0] g,
    output logic [display_pkg::CHANW-1:0] b
);
    import display_pkg::*;

    logic             hsync_d;  // stage 1, lines up with drawing/pix
    logic             vsync_d;
    logic             de_d;
    logic             fg;       // sprite pixel set
    logic [CHANW-1:0] paint_r;
    logic [CHANW-1:0] paint_g;
    logic [CHANW-1:0] paint_b;

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hsync_d <= ~SYNC_ACTIVE;
            vsync_d <= ~SYNC_ACTIVE;
            de_d    <= 1'b0;
        end else begin
            hsync_d <= disp.hsync;
            vsync_d <= disp.vsync;
            de_d    <= disp.de;
        end
    end

    // yellow on blue, black whenever blanked
    always_comb begin
        fg      = drawing && pix;
        paint_r = de_d ? (fg ? FG_R : BG_R) : '0;
        paint_g = de_d ? (fg ? FG_G : BG_G) : '0;
        paint_b = de_d ? (fg ? FG_B : BG_B) : '0;
    end

    // stage 2, all outputs two cycles behind the counters
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hsync <= ~SYNC_ACTIVE;
            vsync <= ~SYNC_ACTIVE;
            de    <= 1'b0;
            r     <= '0;
            g     <= '0;
            b     <= '0;
        end else begin
            hsync <= hsync_d;
            vsync <= vsync_d;
            de    <= de_d;
            r     <= paint_r;
            g     <= paint_g;
            b     <= paint_b;
        end
    end

endmodule

`default_nettype wire

// ==== src/sprite_display_top.sv ====
// ====================
// sprite display top: timing, sprite engine
// and compose stage on one raster bus
// ====================
`default_nettype none

module sprite_display_top (
    input  logic                          clk_pix,    // 25 MHz pixel clock
    input  logic                          reset,      // sync, active high
    input  logic [display_pkg::CORDW-1:0] sprx,       // sprite left edge
    input  logic [display_pkg::CORDW-1:0] spry,       // sprite top edge
    output logic                          vga_hsync,  // negative sync
    output logic                          vga_vsync,  // negative sync
    output logic                          vga_de,
    output logic [display_pkg::CHANW-1:0] vga_r,
    output logic [display_pkg::CHANW-1:0] vga_g,
    output logic [display_pkg::CHANW-1:0] vga_b
);

    logic drawing;  // sprite covers the pixel, one cycle behind the bus
    logic pix;      // bitmap bit at that pixel

    // raster position and strobes
    display_if disp_bus ();

    display_timing timing_i (
        .clk_pix (clk_pix),
        .reset   (reset),
        .disp    (disp_bus.source)
    );

    sprite_engine sprite_i (
        .clk_pix (clk_pix),
        .reset   (reset),
        .disp    (disp_bus.sprite),
        .sprx    (sprx),
        .spry    (spry),
        .drawing (drawing),
        .pix     (pix)
    );

    // final colour and output registers
    pixel_compose compose_i (
        .clk_pix (clk_pix),
        .reset   (reset),
        .disp    (disp_bus.compose),
        .drawing (drawing),
        .pix     (pix),
        .hsync   (vga_hsync),
        .vsync   (vga_vsync),
        .de      (vga_de),
        .r       (vga_r),
        .g       (vga_g),
        .b       (vga_b)
    );

endmodule

`default_nettype wire

// ==== src/sprite_engine.sv ====
// ====================
// sprite engine: frame-latched position, 8x8 bitmap rom,
// row fetch per line and 16x scaled pixel stepping
// ====================
`default_nettype none

module sprite_engine (
    input  logic                          clk_pix,
    input  logic                          reset,
    display_if.sprite                     disp,
    input  logic [display_pkg::CORDW-1:0] sprx,
    input  logic [display_pkg::CORDW-1:0] spry,
    output logic                          drawing,
    output logic                          pix
);
    import display_pkg::*;

    // bitmap, msb of each row is the leftmost column
    logic [SPR_WIDTH-1:0] rom [SPR_HEIGHT];

    logic [CORDW-1:0]     pos_x;      // latched once per frame
    logic [CORDW-1:0]     pos_y;
    logic [CORDW-1:0]     next_line;  // line after the current one
    logic [CORDW-1:0]     line_off;   // next_line relative to sprite top
    logic                 in_block;   // next line crosses the sprite
    logic [SPR_WIDTH-1:0] row_bits;   // bitmap row for this line
    logic                 row_valid;  // this line has sprite content
    logic [SPR_COLW-1:0]  col;        // bitmap column of previous pixel
    logic [SPR_COLW-1:0]  col_nxt;
    logic [SPR_SCALE-1:0] scale_cnt;  // pixels into the current column
    logic [SPR_SCALE-1:0] scale_nxt;
    logic                 start;      // left edge reached
    logic                 run_nxt;    // drawing at the current pixel

    initial begin
        $readmemb(SPR_FILE, rom);
    end

    // position only moves between frames, so no tearing
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            pos_x <= '0;
            pos_y <= '0;
        end else if (disp.frame) begin
            pos_x <= sprx;
            pos_y <= spry;
        end
    end

    // which line comes next and does it hit the sprite
    always_comb begin
        next_line = (disp.sy == CORDW'(V_TOTAL - 1)) ? '0 : disp.sy + 1'b1;
        line_off  = next_line - pos_y;
        in_block  = (next_line >= pos_y)
                 && (line_off < CORDW'(SPR_HEIGHT << SPR_SCALE))
                 && (next_line < CORDW'(V_RES));  // clip at the bottom edge
    end

    // row fetch in horizontal blanking, before the next sx == 0
    always_ff @(posedge clk_pix) begin
        if (disp.line) begin
            row_bits <= rom[line_off[SPR_SCALE +: SPR_ROWW]];  // divide by 16
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            row_valid <= 1'b0;
        end else if (disp.line) begin
            row_valid <= in_block;  // empty line otherwise
        end
    end

    // registered state holds the previous pixel, the
    // next-state values describe the pixel now on the bus
    always_comb begin
        start     = row_valid && !drawing
                 && (disp.sx == pos_x) && (disp.sx < CORDW'(H_RES));
        run_nxt   = drawing;
        col_nxt   = col;
        scale_nxt = scale_cnt;
        if (disp.line) begin
            run_nxt = 1'b0;  // right edge clip, never wraps
        end else if (start) begin
            run_nxt   = 1'b1;
            col_nxt   = '0;
            scale_nxt = '0;
        end else if (drawing) begin
            scale_nxt = scale_cnt + 1'b1;  // rolls over every 16 pixels
            if (scale_cnt == '1) begin
                if (col == SPR_COLW'(SPR_WIDTH - 1)) begin
                    run_nxt = 1'b0;  // past the last column
                end else begin
                    col_nxt = col + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            drawing   <= 1'b0;
            pix       <= 1'b0;
            col       <= '0;
            scale_cnt <= '0;
        end else begin
            drawing   <= run_nxt;
            pix       <= run_nxt && row_bits[SPR_WIDTH - 1 - int'(col_nxt)];
            col       <= col_nxt;
            scale_cnt <= scale_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== tests/sprite_display_sva.sv ====
// ====================
// bound checks on hsync width and
// output blanking, bound to the top level
// ====================
`default_nettype none

module sprite_display_sva (
    input logic                          clk_pix,
    input logic                          reset,
    input logic                          vga_hsync,
    input logic                          vga_de,
    input logic [display_pkg::CHANW-1:0] vga_r,
    input logic [display_pkg::CHANW-1:0] vga_g,
    input logic [display_pkg::CHANW-1:0] vga_b
);
    timeunit 1ns;
    timeprecision 1ps;
    import display_pkg::*;

    logic [CORDW-1:0] hs_low_cnt;  // cycles hsync has been active
    logic             seen_reset;  // reset sampled at least once

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hs_low_cnt <= '0;
            seen_reset <= 1'b1;
        end else if (vga_hsync == SYNC_ACTIVE) begin
            hs_low_cnt <= hs_low_cnt + 1'b1;
        end else begin
            hs_low_cnt <= '0;  // idle level clears the count
        end
    end

    // pulse ends after exactly H_SYNC active cycles
    hsync_width_a : assert property (@(posedge clk_pix) disable iff (reset)
        $rose(vga_hsync) |-> hs_low_cnt == CORDW'(H_SYNC))
        else $error("hsync pulse width differs from H_SYNC");

    blank_black_a : assert property (@(posedge clk_pix)
        seen_reset && !vga_de |-> (vga_r == '0) && (vga_g == '0) && (vga_b == '0))
        else $error("colour outputs are not black outside the active area");

    reset_de_low_a : assert property (@(posedge clk_pix)
        seen_reset && reset |-> !vga_de)
        else $error("vga_de is high during reset");

endmodule

bind sprite_display_top sprite_display_sva sva_i (
    .clk_pix   (clk_pix),
    .reset     (reset),
    .vga_hsync (vga_hsync),
    .vga_de    (vga_de),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b)
);

`default_nettype wire

// ==== tests/tb_sprite_display.sv ====
// ====================
// sprite display testbench: raster tracking,
// reference colour model, timing and pixel compares
// ====================
`default_nettype none

module tb_sprite_display;
    timeunit 1ns;
    timeprecision 1ps;
    import display_pkg::*;

    localparam int CLK_PERIOD   = 40;                       // 25 MHz pixel clock
    localparam int RESET_CYCLES = 4;
    localparam int N_FRAMES     = 4;                        // frames compared pixel by pixel
    localparam int BLOCK_W      = SPR_WIDTH << SPR_SCALE;   // 128
    localparam int BLOCK_H      = SPR_HEIGHT << SPR_SCALE;  // 128
    localparam int X_IN         = H_RES - BLOCK_W;          // last x with the whole block
    localparam int Y_IN         = V_RES - BLOCK_H;
    localparam int EDGE_SPAN    = 120;                      // clipped positions past X_IN/Y_IN
    localparam longint WATCHDOG_NS =
        longint'(N_FRAMES + 2) * H_TOTAL * V_TOTAL * CLK_PERIOD + 100_000;

    // letter F, msb is the leftmost column
    localparam logic [SPR_WIDTH-1:0] LETTER_F [SPR_HEIGHT] = '{
        8'b1111_1110,
        8'b1111_1110,
        8'b1100_0000,
        8'b1111_1100,
        8'b1111_1100,
        8'b1100_0000,
        8'b1100_0000,
        8'b0000_0000
    };

    logic             clk_pix;
    logic             reset;
    logic [CORDW-1:0] sprx;
    logic [CORDW-1:0] spry;
    logic             vga_hsync;
    logic             vga_vsync;
    logic             vga_de;
    logic [CHANW-1:0] vga_r;
    logic [CHANW-1:0] vga_g;
    logic [CHANW-1:0] vga_b;

    // raster tracker state, all taken from the DUT ports
    logic             de_q = 1'b0;
    logic             hs_q = 1'b1;
    logic             vs_q = 1'b1;
    logic             synced = 1'b0;        // a full vsync pulse was seen
    logic             frame_active = 1'b0;  // frame under comparison
    logic [CORDW-1:0] x_cur = '0;
    logic [CORDW-1:0] y_cur = '0;
    logic [CORDW-1:0] cur_px = '0;          // position in force for the frame
    logic [CORDW-1:0] cur_py = '0;
    logic [CORDW-1:0] pend_px = '0;         // driven at the last vsync rise
    logic [CORDW-1:0] pend_py = '0;
    int               de_len = 0;
    int               line_rises = 0;
    int               hs_low = 0;
    int               vs_lines = 0;
    int               period = 0;
    int               frames_done = 0;
    int               pixel_checks = 0;
    logic [31:0]      rng_state = 32'd36892;
    logic [CHANW-1:0] exp_r;
    logic [CHANW-1:0] exp_g;
    logic [CHANW-1:0] exp_b;

    sprite_display_top dut_i (
        .clk_pix   (clk_pix),
        .reset     (reset),
        .sprx      (sprx),
        .spry      (spry),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_de    (vga_de),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

    initial begin
        clk_pix = 1'b0;
        forever #(CLK_PERIOD / 2) clk_pix = ~clk_pix;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // saturates so a runaway count never aliases a legal value
    function automatic logic [CORDW-1:0] to_count(input int n);
        return (n > (1 << CORDW) - 1) ? '1 : CORDW'(n);
    endfunction

    // yellow where the magnified bitmap has a 1, blue elsewhere
    function automatic logic [3*CHANW-1:0] expected_colour(
        input logic [CORDW-1:0] x, y, px, py
    );
        int   dx;
        int   dy;
        logic hit;
        dx  = int'(x) - int'(px);
        dy  = int'(y) - int'(py);
        hit = 1'b0;
        if (dx >= 0 && dx < BLOCK_W && dy >= 0 && dy < BLOCK_H) begin
            hit = LETTER_F[dy >> SPR_SCALE][SPR_WIDTH - 1 - (dx >> SPR_SCALE)];
        end
        return hit ? {FG_R, FG_G, FG_B} : {BG_R, BG_G, BG_B};
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_colour(input string where, input int x, input int y,
                                input logic [CHANW-1:0] r, g, b, er, eg, eb);
        if ({r, g, b} !== {er, eg, eb}) begin
            stop_on_error($sformatf(
                "MISMATCH vga_r/vga_g/vga_b %s x %0d y %0d: got %h %h %h expected %h %h %h",
                where, x, y, r, g, b, er, eg, eb));
        end
    endtask

    task automatic check_timing(input string name, input logic [CORDW-1:0] got, exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_level(input string name, input logic got, exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_idle();
        check_level("vga_de", vga_de, 1'b0);
        check_level("vga_hsync", vga_hsync, ~SYNC_ACTIVE);  // syncs idle high
        check_level("vga_vsync", vga_vsync, ~SYNC_ACTIVE);
        check_colour("in reset", 0, 0, vga_r, vga_g, vga_b, '0, '0, '0);
    endtask

    // k 0 whole sprite, 1 right clip, 2 bottom clip, 3 both
    task automatic next_position(input int k, output logic [CORDW-1:0] px, py);
        int rx;
        int ry;
        rng_state = lcg_next(rng_state);
        rx        = int'(rng_state >> 16);
        rng_state = lcg_next(rng_state);
        ry        = int'(rng_state >> 16);
        px        = CORDW'(rx % (X_IN + 1));
        py        = CORDW'(ry % (Y_IN + 1));
        if (k == 1 || k == 3) begin
            px = CORDW'(X_IN + 1 + rx % EDGE_SPAN);  // above 512
        end
        if (k == 2 || k == 3) begin
            py = CORDW'(Y_IN + 1 + ry % EDGE_SPAN);  // above 352
        end
    endtask

    initial begin
        reset = 1'b1;
        sprx  = '0;
        spry  = '0;
        @(posedge clk_pix);
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk_pix);
            check_idle();
            @(posedge clk_pix);
        end
        reset <= 1'b0;
        repeat (2) begin  // reset values still in the two pipeline stages
            @(negedge clk_pix);
            check_idle();
        end
        wait (frames_done == N_FRAMES);
        if (pixel_checks > 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            stop_on_error("no active pixel was compared");
        end
    end

    // new position at every vsync rise, latched by the DUT at the frame strobe
    initial begin
        logic [CORDW-1:0] nx;
        logic [CORDW-1:0] ny;
        int               k;
        k = 0;
        @(negedge reset);
        forever begin
            @(posedge vga_vsync);
            @(posedge clk_pix);
            next_position(k, nx, ny);
            sprx    <= nx;
            spry    <= ny;
            pend_px = nx;
            pend_py = ny;
            k       = k + 1;
            @(posedge vga_de);  // first line of the frame this position governs
            @(posedge clk_pix);
            sprx    <= ~nx;     // decoy that only the next frame strobe may pick up
            spry    <= ~ny;
        end
    end

    // raster tracking and compares, sampled mid-cycle
    always @(negedge clk_pix) begin
        if (!reset) begin
            if (!vga_de) begin
                check_colour("blanking", x_cur, y_cur, vga_r, vga_g, vga_b, '0, '0, '0);
            end
            period = period + 1;
            if (vga_hsync == SYNC_ACTIVE) begin
                hs_low = hs_low + 1;
            end
            if (vga_hsync != SYNC_ACTIVE && hs_q == SYNC_ACTIVE) begin
                if (synced) begin
                    check_timing("vga_hsync width", to_count(hs_low), CORDW'(H_SYNC));
                end
                hs_low = 0;
            end
            // each hsync start inside vsync is one vsync line
            if (vga_hsync == SYNC_ACTIVE && hs_q != SYNC_ACTIVE
                && vga_vsync == SYNC_ACTIVE) begin
                vs_lines = vs_lines + 1;
            end
            if (vga_vsync == SYNC_ACTIVE && vs_q != SYNC_ACTIVE) begin  // frame closes
                if (frame_active) begin
                    check_timing("active lines", to_count(line_rises), CORDW'(V_RES));
                    frames_done = frames_done + 1;
                end
                frame_active = 1'b0;
                line_rises   = 0;
                vs_lines     = 0;
            end
            if (vga_vsync != SYNC_ACTIVE && vs_q == SYNC_ACTIVE) begin
                if (synced) begin
                    check_timing("vga_vsync lines", to_count(vs_lines), CORDW'(V_SYNC));
                end
                synced = 1'b1;
            end
            if (vga_de && !de_q) begin
                if (line_rises == 0 && synced) begin  // first line takes the new position
                    cur_px       = pend_px;
                    cur_py       = pend_py;
                    frame_active = 1'b1;
                end else if (frame_active) begin
                    check_timing("line period", to_count(period), CORDW'(H_TOTAL));
                end
                period     = 0;
                x_cur      = '0;
                y_cur      = to_count(line_rises);
                line_rises = line_rises + 1;
                de_len     = 0;
            end else if (vga_de) begin
                x_cur = x_cur + 1'b1;
            end
            if (vga_de) begin
                de_len = de_len + 1;
            end
            if (!vga_de && de_q && frame_active) begin
                check_timing("vga_de cycles per line", to_count(de_len), CORDW'(H_RES));
            end
            if (vga_de && frame_active) begin
                {exp_r, exp_g, exp_b} = expected_colour(x_cur, y_cur, cur_px, cur_py);
                check_colour("active", x_cur, y_cur, vga_r, vga_g, vga_b, exp_r, exp_g, exp_b);
                pixel_checks = pixel_checks + 1;
            end
        end
        de_q = vga_de;
        hs_q = vga_hsync;
        vs_q = vga_vsync;
    end

    // about six frames of raster time
    initial begin
        #(WATCHDOG_NS);
        stop_on_error("timeout: the raster did not finish the test frames in time");
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/display_pkg.sv
src/display_if.sv
src/display_timing.sv
src/sprite_engine.sv
src/pixel_compose.sv
src/sprite_display_top.sv
tests/sprite_display_sva.sv
tests/tb_sprite_display.sv
